// ==== Makefile ====
TOP = streamer_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "Simulation ended early"; exit 1; }

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== bench/streamer_chk.sv ====
`include "streamer_params.svh"

module streamer_chk (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    z_priority_i,
  input logic                    ld_req_i,
  input logic                    ld_gnt_i,
  input logic                    st_req_i,
  input logic                    st_gnt_i,
  input logic                    tcdm_req_i,
  input logic                    tcdm_gnt_i,
  input logic                    tcdm_wen_i,
  input logic                    tcdm_r_valid_i,
  input logic                    x_valid_i,
  input logic                    x_ready_i,
  input logic [`STREAMER_DW-1:0] x_data_i,
  input logic                    z_ready_i,
  input logic                    ld_done_i,
  input logic                    st_done_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [3:0]  outst_q;
  // Failed assertions so far, read by the testbench verdict
  int unsigned err_cnt = 0;

  // Reads accepted on the port minus responses seen
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outst_q <= '0;
    end else if ((tcdm_req_i && tcdm_gnt_i && tcdm_wen_i) != tcdm_r_valid_i) begin
      outst_q <= tcdm_r_valid_i ? outst_q - 1'b1 : outst_q + 1'b1;
    end
  end

  // A channel grant only follows a handshake on the port
  grant_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ld_gnt_i || st_gnt_i |-> tcdm_req_i && tcdm_gnt_i)
    else begin
      $error("channel grant without a port request");
      err_cnt++;
    end

  // Accepted request reaches exactly one channel, reads go to load
  grant_one_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tcdm_req_i && tcdm_gnt_i |-> (ld_gnt_i != st_gnt_i) && (ld_gnt_i == tcdm_wen_i))
    else begin
      $error("port accept not routed to its owner");
      err_cnt++;
    end

  // Tie goes to store only under Z priority
  tie_follows_priority: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ld_req_i && st_req_i |-> tcdm_wen_i == !z_priority_i)
    else begin
      $error("tie resolved against the Z priority");
      err_cnt++;
    end

  // X payload is frozen while stalled
  x_data_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    x_valid_i && !x_ready_i |=> $stable(x_data_i))
    else begin
      $error("x_data_o changed under stall");
      err_cnt++;
    end

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> !tcdm_req_i && !x_valid_i && !z_ready_i && !ld_done_i && !st_done_i)
    else begin
      $error("outputs active during reset");
      err_cnt++;
    end

  credit_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    outst_q <= 4'(`STREAMER_LD_DEPTH))
    else begin
      $error("more than four reads outstanding");
      err_cnt++;
    end

endmodule

bind streamer_top streamer_chk i_chk (
  .clk_i          ( clk_i          ),
  .rst_n_i        ( rst_n_i        ),
  .z_priority_i   ( z_priority_i   ),
  .ld_req_i       ( ld_req         ),
  .ld_gnt_i       ( ld_gnt         ),
  .st_req_i       ( st_req         ),
  .st_gnt_i       ( st_gnt         ),
  .tcdm_req_i     ( tcdm_req_o     ),
  .tcdm_gnt_i     ( tcdm_gnt_i     ),
  .tcdm_wen_i     ( tcdm_wen_o     ),
  .tcdm_r_valid_i ( tcdm_r_valid_i ),
  .x_valid_i      ( x_valid_o      ),
  .x_ready_i      ( x_ready_i      ),
  .x_data_i       ( x_data_o       ),
  .z_ready_i      ( z_ready_o      ),
  .ld_done_i      ( ld_done_o      ),
  .st_done_i      ( st_done_o      )
);

// ==== bench/streamer_monitor.sv ====
`include "streamer_params.svh"

module streamer_monitor (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      test_start_i,
  input  logic [`STREAMER_DW-1:0]   exp_x_i [64],
  input  int unsigned               n_x_i,
  input  logic [`STREAMER_AW-1:0]   exp_wa_i [64],
  input  logic [`STREAMER_DW-1:0]   exp_wd_i [64],
  input  logic [3:0]                exp_wb_i [64],
  input  int unsigned               n_w_i,
  input  logic                      x_valid_i,
  input  logic                      x_ready_i,
  input  logic [`STREAMER_DW-1:0]   x_data_i,
  input  logic                      ld_done_i,
  input  logic                      tcdm_req_i,
  input  logic                      tcdm_gnt_i,
  input  logic                      tcdm_wen_i,
  input  logic [`STREAMER_AW-1:0]   tcdm_add_i,
  input  logic [`STREAMER_DW-1:0]   tcdm_data_i,
  input  logic [`STREAMER_DW/8-1:0] tcdm_be_i,
  input  logic                      st_done_i,
  output int unsigned               err_cnt_o,
  output int unsigned               x_seen_o,
  output int unsigned               w_seen_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import streamer_pkg::*;

  grant_owner_e owner;

  // Sampled mid-cycle, where all DUT outputs have settled
  always @(negedge clk_i) begin
    owner = tcdm_wen_i ? OWNER_LOAD : OWNER_STORE;
    if (!rst_n_i) begin
      err_cnt_o = 0;
      x_seen_o  = 0;
      w_seen_o  = 0;
    end else if (test_start_i) begin
      x_seen_o = 0;
      w_seen_o = 0;
    end else begin
      if (x_valid_i && x_ready_i) begin
        if (x_seen_o >= n_x_i) begin
          $display("X transfer %0d beyond the expected count", x_seen_o);
          err_cnt_o++;
        end else begin
          if (x_data_i !== exp_x_i[x_seen_o]) begin
            $display("FAIL x_data_o exp 0x%08h got 0x%08h", exp_x_i[x_seen_o], x_data_i);
            err_cnt_o++;
          end
          // Done only with the final word
          if (ld_done_i !== (x_seen_o == n_x_i - 1)) begin
            $display("FAIL ld_done_o exp 0x%0h got 0x%0h", x_seen_o == n_x_i - 1, ld_done_i);
            err_cnt_o++;
          end
        end
        x_seen_o++;
      end else if (ld_done_i) begin
        $display("ld_done_o pulsed without an X transfer");
        err_cnt_o++;
      end
      if (tcdm_req_i && tcdm_gnt_i && owner == OWNER_STORE) begin
        if (w_seen_o >= n_w_i) begin
          $display("Write by %s beyond the expected count", owner.name());
          err_cnt_o++;
        end else begin
          if (tcdm_add_i !== exp_wa_i[w_seen_o]) begin
            $display("FAIL tcdm_add_o exp 0x%08h got 0x%08h", exp_wa_i[w_seen_o], tcdm_add_i);
            err_cnt_o++;
          end
          if (tcdm_data_i !== exp_wd_i[w_seen_o]) begin
            $display("FAIL tcdm_data_o exp 0x%08h got 0x%08h", exp_wd_i[w_seen_o], tcdm_data_i);
            err_cnt_o++;
          end
          if (tcdm_be_i !== exp_wb_i[w_seen_o]) begin
            $display("FAIL tcdm_be_o exp 0x%0h got 0x%0h", exp_wb_i[w_seen_o], tcdm_be_i);
            err_cnt_o++;
          end
          if (st_done_i !== (w_seen_o == n_w_i - 1)) begin
            $display("FAIL st_done_o exp 0x%0h got 0x%0h", w_seen_o == n_w_i - 1, st_done_i);
            err_cnt_o++;
          end
        end
        w_seen_o++;
      end else if (st_done_i) begin
        $display("st_done_o pulsed without a granted write");
        err_cnt_o++;
      end
    end
  end

endmodule

// ==== bench/streamer_tb.sv ====
`include "streamer_params.svh"

module streamer_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import streamer_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        clear;
  logic        start;
  cast_mode_e  cast_mode;
  logic        z_priority;
  logic [31:0] ld_base;
  logic [31:0] ld_stride;
  logic [15:0] ld_len;
  logic [31:0] st_base;
  logic [31:0] st_stride;
  logic [15:0] st_len;
  logic        x_valid;
  logic [31:0] x_data;
  logic        x_ready;
  logic        z_valid;
  logic [31:0] z_data;
  logic        z_ready;
  logic        tcdm_req;
  logic        tcdm_gnt;
  logic [31:0] tcdm_add;
  logic        tcdm_wen;
  logic [31:0] tcdm_data;
  logic [3:0]  tcdm_be;
  logic        r_valid;
  logic [31:0] r_data;
  logic        ld_done;
  logic        st_done;

  // Flat test data image, word 0 holds the number of tests
  logic [31:0] td [256];
  logic [31:0] exp_x [64];
  logic [31:0] exp_wa [64];
  logic [31:0] exp_wd [64];
  logic [3:0]  exp_wb [64];
  int unsigned n_x;
  int unsigned n_w;
  logic [31:0] z_words [64];
  int unsigned z_n;
  int unsigned z_idx;
  logic [31:0] mem [logic [29:0]];
  logic [31:0] rd_q [$];
  int unsigned lat_cnt;
  int unsigned mem_errs;
  int unsigned total_words;
  logic        test_start;
  int unsigned mon_err;
  int unsigned x_seen;
  int unsigned w_seen;
  int          ptr;

  streamer_top i_dut (
    .clk_i (clk), .rst_n_i (rst_n), .clear_i (clear), .start_i (start),
    .cast_mode_i (cast_mode), .z_priority_i (z_priority),
    .ld_base_i (ld_base), .ld_stride_i (ld_stride), .ld_len_i (ld_len),
    .st_base_i (st_base), .st_stride_i (st_stride), .st_len_i (st_len),
    .x_valid_o (x_valid), .x_data_o (x_data), .x_ready_i (x_ready),
    .z_valid_i (z_valid), .z_data_i (z_data), .z_ready_o (z_ready),
    .tcdm_req_o (tcdm_req), .tcdm_gnt_i (tcdm_gnt), .tcdm_add_o (tcdm_add),
    .tcdm_wen_o (tcdm_wen), .tcdm_data_o (tcdm_data), .tcdm_be_o (tcdm_be),
    .tcdm_r_valid_i (r_valid), .tcdm_r_data_i (r_data),
    .ld_done_o (ld_done), .st_done_o (st_done)
  );

  streamer_monitor i_monitor (
    .clk_i (clk), .rst_n_i (rst_n), .test_start_i (test_start),
    .exp_x_i (exp_x), .n_x_i (n_x), .exp_wa_i (exp_wa), .exp_wd_i (exp_wd),
    .exp_wb_i (exp_wb), .n_w_i (n_w),
    .x_valid_i (x_valid), .x_ready_i (x_ready), .x_data_i (x_data), .ld_done_i (ld_done),
    .tcdm_req_i (tcdm_req), .tcdm_gnt_i (tcdm_gnt), .tcdm_wen_i (tcdm_wen),
    .tcdm_add_i (tcdm_add), .tcdm_data_i (tcdm_data), .tcdm_be_i (tcdm_be),
    .st_done_i (st_done), .err_cnt_o (mon_err), .x_seen_o (x_seen), .w_seen_o (w_seen)
  );

  always #5 clk = ~clk;

  // Untouched words read back a pattern of their own address
  function automatic logic [31:0] read_word(logic [31:0] addr);
    return mem.exists(addr[31:2]) ? mem[addr[31:2]] : (addr ^ 32'h5a5a_0000);
  endfunction

  task automatic write_word(logic [31:0] addr, logic [31:0] data, logic [3:0] be);
    logic [31:0] word;
    word = read_word(addr);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) word[8*b +: 8] = data[8*b +: 8];
    end
    mem[addr[31:2]] = word;
  endtask

  // Sum of X and Z words over all tests, for the watchdog
  function automatic int unsigned count_words();
    int unsigned p;
    int unsigned sum;
    int unsigned nx;
    int unsigned nw;
    p   = 1;
    sum = 0;
    for (int t = 0; t < int'(td[0]); t++) begin
      nx  = td[p+4];
      nw  = td[p+7];
      p   = p + 9 + 2 * td[p+8] + nw + nx + 3 * nw;
      p   = p + 1 + 2 * td[p];
      sum = sum + nx + nw;
    end
    return sum;
  endfunction

  // Memory port and stream driver, sample mid-cycle and drive 1 ns after the edge
  // All random stalls and latencies come from this process
  initial begin
    void'($urandom(32'h3f6a430b));
    forever begin
      @(negedge clk);
      if (rst_n && tcdm_req && tcdm_gnt) begin
        if (tcdm_wen) rd_q.push_back(read_word(tcdm_add));
        else write_word(tcdm_add, tcdm_data, tcdm_be);
      end
      if (z_valid && z_ready) z_idx++;
      @(posedge clk);
      #1;
      tcdm_gnt = ($urandom % 4) != 0;
      x_ready  = ($urandom % 3) != 0;
      r_valid  = 1'b0;
      // In-order responses, 1 to 3 cycles each
      if (rd_q.size() > 0) begin
        if (lat_cnt == 0) begin
          r_valid = 1'b1;
          r_data  = rd_q.pop_front();
          lat_cnt = $urandom % 3;
        end else begin
          lat_cnt--;
        end
      end
      z_valid = (z_idx < z_n);
      z_data  = z_valid ? z_words[z_idx] : 32'h0;
    end
  end

  task automatic run_test(inout int p);
    int unsigned n_pre;
    int unsigned n_fin;
    logic [31:0] got;
    cast_mode  = cast_mode_e'(td[p][0]);
    z_priority = td[p+1][0];
    n_x        = td[p+4];
    n_w        = td[p+7];
    n_pre      = td[p+8];
    @(posedge clk);
    #1;
    ld_base   = td[p+2];
    ld_stride = td[p+3];
    ld_len    = td[p+4][15:0];
    st_base   = td[p+5];
    st_stride = td[p+6];
    st_len    = td[p+7][15:0];
    p = p + 9;
    mem.delete();
    for (int i = 0; i < int'(n_pre); i++) begin
      mem[td[p][31:2]] = td[p+1];
      p = p + 2;
    end
    for (int i = 0; i < int'(n_w); i++) begin
      z_words[i] = td[p];
      p++;
    end
    for (int i = 0; i < int'(n_x); i++) begin
      exp_x[i] = td[p];
      p++;
    end
    for (int i = 0; i < int'(n_w); i++) begin
      exp_wa[i] = td[p];
      exp_wd[i] = td[p+1];
      exp_wb[i] = td[p+2][3:0];
      p = p + 3;
    end
    z_idx      = 0;
    z_n        = n_w;
    test_start = 1'b1;
    @(posedge clk);
    #1;
    test_start = 1'b0;
    start      = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    while (!(x_seen == n_x && w_seen == n_w && rd_q.size() == 0)) @(posedge clk);
    repeat (4) @(posedge clk);
    // Final memory image after both channels are done
    n_fin = td[p];
    p++;
    for (int i = 0; i < int'(n_fin); i++) begin
      got = read_word(td[p]);
      if (got !== td[p+1]) begin
        $display("FAIL mem[0x%08h] exp 0x%08h got 0x%08h", td[p], td[p+1], got);
        mem_errs++;
      end
      p = p + 2;
    end
  endtask

  initial begin
    wait (total_words != 0);
    repeat (200 * total_words) @(posedge clk);
    $display("Timeout after %0d cycles, the run did not complete", 200 * total_words);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    clk        = 0;
    rst_n      = 0;
    clear      = 0;
    start      = 0;
    cast_mode  = CAST_NONE;
    z_priority = 0;
    ld_base    = 0;
    ld_stride  = 0;
    ld_len     = 0;
    st_base    = 0;
    st_stride  = 0;
    st_len     = 0;
    x_ready    = 0;
    z_valid    = 0;
    z_data     = 0;
    tcdm_gnt   = 0;
    r_valid    = 0;
    r_data     = 0;
    test_start = 0;
    z_n        = 0;
    z_idx      = 0;
    n_x        = 0;
    n_w        = 0;
    lat_cnt    = 0;
    mem_errs   = 0;
    $readmemh("bench/streamer_testdata.txt", td);
    total_words = count_words();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1;
    ptr = 1;
    for (int t = 0; t < int'(td[0]); t++) run_test(ptr);
    $display("Errors: monitor %0d, memory %0d, assertions %0d", mon_err, mem_errs,
             i_dut.i_chk.err_cnt);
    if (mon_err == 0 && mem_errs == 0 && i_dut.i_chk.err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== bench/streamer_testdata.txt ====
// Hex words. First word is the test count. Per test header:
// cast zprio ld_base ld_stride ld_len st_base st_stride st_len n_preload,
// then preload (addr data) pairs, Z words, expected X words,
// expected writes (addr data be), count of final words, final (addr data) pairs
00000003
// Plain load, stride 8, no store
0 0 100 8 4 0 0 0 4
100 11111111 108 22222222 110 33333333 118 44444444
11111111 22222222 33333333 44444444
0
// FP8 cast on both channels, load has priority
1 0 200 8 3 300 4 2 5
200 11223344 208 A5B6C7D8 210 00FF7F80 300 FFFFFFFF 304 00000000
12345678 ABCDEF01
33004400 C700D800 7F008000
300 00001256 3 304 0000ABEF 3
2 300 FFFF1256 304 0000ABEF
// Plain, store has priority
0 1 400 4 2 500 C 3 2
400 DEADBEEF 404 CAFEF00D
01010101 02020202 03030303
DEADBEEF CAFEF00D
500 01010101 F 50C 02020202 F 518 03030303 F
3 500 01010101 50C 02020202 518 03030303

// ==== project.f ====
+incdir+src
src/streamer_pkg.sv
src/addr_gen.sv
src/load_channel.sv
src/store_channel.sv
src/tcdm_arbiter.sv
src/streamer_top.sv
bench/streamer_chk.sv
bench/streamer_monitor.sv
bench/streamer_tb.sv

// ==== src/addr_gen.sv ====
`include "streamer_params.svh"

module addr_gen (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       clear_i,
  input  logic                       start_i,
  input  logic [`STREAMER_AW-1:0]    base_i,
  input  logic [`STREAMER_AW-1:0]    stride_i,
  input  logic [`STREAMER_LEN_W-1:0] len_i,
  input  logic                       accept_i,
  output logic                       active_o,
  output logic [`STREAMER_AW-1:0]    addr_o,
  output logic                       last_o
);
  import streamer_pkg::*;

  addr_state_e               state_q;
  logic [`STREAMER_AW-1:0]    addr_q;
  logic [`STREAMER_LEN_W-1:0] remain_q;

  // Control part, state and words still to hand out
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ADDR_IDLE;
      remain_q <= '0;
    end else if (clear_i) begin
      state_q  <= ADDR_IDLE;
      remain_q <= '0;
    end else if (start_i) begin
      // Zero length run never leaves idle
      state_q  <= (len_i != '0) ? ADDR_RUN : ADDR_IDLE;
      remain_q <= len_i;
    end else if (accept_i && state_q == ADDR_RUN) begin
      remain_q <= remain_q - 1'b1;
      if (last_o) begin
        state_q <= ADDR_IDLE;
      end
    end
  end

  // Address register, base on start then one stride per accept
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= base_i;
    end else if (accept_i && state_q == ADDR_RUN) begin
      addr_q <= addr_q + stride_i;
    end
  end

  assign active_o = (state_q == ADDR_RUN);
  assign addr_o   = addr_q;
  // Final address of the run
  assign last_o   = active_o && (remain_q == `STREAMER_LEN_W'(1));

endmodule

// ==== src/load_channel.sv ====
`include "streamer_params.svh"

module load_channel (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       clear_i,
  input  logic                       start_i,
  input  streamer_pkg::cast_mode_e   cast_mode_i,
  input  logic [`STREAMER_AW-1:0]    base_i,
  input  logic [`STREAMER_AW-1:0]    stride_i,
  input  logic [`STREAMER_LEN_W-1:0] len_i,
  input  logic                       gnt_i,
  input  logic                       r_valid_i,
  input  logic [`STREAMER_DW-1:0]    r_data_i,
  input  logic                       x_ready_i,
  output logic                       req_o,
  output logic [`STREAMER_AW-1:0]    add_o,
  output logic                       x_valid_o,
  output logic [`STREAMER_DW-1:0]    x_data_o,
  output logic                       done_o
);
  import streamer_pkg::*;

  localparam int unsigned DEPTH = `STREAMER_LD_DEPTH;
  // Depth is a power of two, pointers wrap on their own
  localparam int unsigned PW    = $clog2(DEPTH);
  localparam int unsigned CW    = $clog2(DEPTH + 1);

  logic                       start_q;
  logic [`STREAMER_AW-1:0]    base_q;
  logic [`STREAMER_AW-1:0]    stride_q;
  logic [`STREAMER_LEN_W-1:0] len_q;
  logic                       gen_active;
  logic                       accept;
  logic                       pop;
  logic [CW-1:0]              outst_q;
  logic [CW-1:0]              cnt_q;
  logic [CW:0]                used;
  logic [PW-1:0]              wptr_q;
  logic [PW-1:0]              rptr_q;
  logic [`STREAMER_DW-1:0]    mem_q [DEPTH];
  logic [`STREAMER_LEN_W-1:0] left_q;

  // Start register, config is captured with the raw pulse
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start_i & ~clear_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      base_q   <= base_i;
      stride_q <= stride_i;
      len_q    <= len_i;
    end
  end

  addr_gen i_addr_gen (
    .clk_i    ( clk_i      ),
    .rst_n_i  ( rst_n_i    ),
    .clear_i  ( clear_i    ),
    .start_i  ( start_q    ),
    .base_i   ( base_q     ),
    .stride_i ( stride_q   ),
    .len_i    ( len_q      ),
    .accept_i ( accept     ),
    .active_o ( gen_active ),
    .addr_o   ( add_o      ),
    .last_o   (            )
  );

  // Credit check, every read in flight owns a FIFO slot
  assign used   = outst_q + cnt_q;
  assign req_o  = gen_active && (used < (CW + 1)'(DEPTH));
  assign accept = req_o & gnt_i;
  assign pop    = x_valid_o & x_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outst_q <= '0;
      cnt_q   <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else if (clear_i) begin
      outst_q <= '0;
      cnt_q   <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else begin
      // Granted read adds one, response retires one
      if (accept != r_valid_i) begin
        outst_q <= accept ? outst_q + 1'b1 : outst_q - 1'b1;
      end
      // Responses always land, the slot was reserved at issue
      if (r_valid_i) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      if (r_valid_i != pop) begin
        cnt_q <= r_valid_i ? cnt_q + 1'b1 : cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_valid_i) begin
      mem_q[wptr_q] <= r_data_i;
    end
  end

  // Head of FIFO drives X, cast on the way out
  assign x_valid_o = (cnt_q != '0);
  assign x_data_o  = (cast_mode_i == CAST_FP8) ? fp8_to_fp16_pair(mem_q[rptr_q]) : mem_q[rptr_q];

  // Words still to deliver on X
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      left_q <= '0;
    end else if (clear_i) begin
      left_q <= '0;
    end else if (start_q) begin
      left_q <= len_q;
    end else if (pop && left_q != '0) begin
      left_q <= left_q - 1'b1;
    end
  end

  assign done_o = pop && (left_q == `STREAMER_LEN_W'(1));

endmodule

// ==== src/store_channel.sv ====
`include "streamer_params.svh"

module store_channel (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       clear_i,
  input  logic                       start_i,
  input  streamer_pkg::cast_mode_e   cast_mode_i,
  input  logic [`STREAMER_AW-1:0]    base_i,
  input  logic [`STREAMER_AW-1:0]    stride_i,
  input  logic [`STREAMER_LEN_W-1:0] len_i,
  input  logic                       z_valid_i,
  input  logic [`STREAMER_DW-1:0]    z_data_i,
  input  logic                       gnt_i,
  output logic                       z_ready_o,
  output logic                       req_o,
  output logic [`STREAMER_AW-1:0]    add_o,
  output logic [`STREAMER_DW-1:0]    data_o,
  output logic [`STREAMER_DW/8-1:0]  be_o,
  output logic                       done_o
);
  import streamer_pkg::*;

  localparam int unsigned DEPTH = `STREAMER_ST_DEPTH;
  localparam int unsigned PW    = $clog2(DEPTH);
  localparam int unsigned CW    = $clog2(DEPTH + 1);

  logic                       start_q;
  logic [`STREAMER_AW-1:0]    base_q;
  logic [`STREAMER_AW-1:0]    stride_q;
  logic [`STREAMER_LEN_W-1:0] len_q;
  logic                       gen_active;
  logic                       gen_last;
  logic                       accept;
  logic                       push;
  logic [`STREAMER_DW-1:0]    z_word;
  logic [CW-1:0]              cnt_q;
  logic [PW-1:0]              wptr_q;
  logic [PW-1:0]              rptr_q;
  logic [`STREAMER_DW-1:0]    mem_q [DEPTH];
  logic [`STREAMER_LEN_W-1:0] in_left_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start_i & ~clear_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      base_q   <= base_i;
      stride_q <= stride_i;
      len_q    <= len_i;
    end
  end

  addr_gen i_addr_gen (
    .clk_i    ( clk_i      ),
    .rst_n_i  ( rst_n_i    ),
    .clear_i  ( clear_i    ),
    .start_i  ( start_q    ),
    .base_i   ( base_q     ),
    .stride_i ( stride_q   ),
    .len_i    ( len_q      ),
    .accept_i ( accept     ),
    .active_o ( gen_active ),
    .addr_o   ( add_o      ),
    .last_o   ( gen_last   )
  );

  // Z is taken only while words of the run remain and a slot is free
  assign z_ready_o = (in_left_q != '0) && (cnt_q != CW'(DEPTH));
  assign push      = z_valid_i & z_ready_o;
  assign z_word    = (cast_mode_i == CAST_FP8) ? fp16_to_fp8_pair(z_data_i) : z_data_i;

  // One write per buffered word at the next generated address
  assign req_o  = (cnt_q != '0) && gen_active;
  assign accept = req_o & gnt_i;
  assign data_o = mem_q[rptr_q];
  // FP8 result only fills the low half
  assign be_o   = (cast_mode_i == CAST_FP8) ? 4'b0011 : 4'b1111;
  assign done_o = accept & gen_last;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q     <= '0;
      wptr_q    <= '0;
      rptr_q    <= '0;
      in_left_q <= '0;
    end else if (clear_i) begin
      cnt_q     <= '0;
      wptr_q    <= '0;
      rptr_q    <= '0;
      in_left_q <= '0;
    end else begin
      if (start_q) begin
        in_left_q <= len_q;
      end else if (push) begin
        in_left_q <= in_left_q - 1'b1;
      end
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (accept) begin
        rptr_q <= rptr_q + 1'b1;
      end
      if (push != accept) begin
        cnt_q <= push ? cnt_q + 1'b1 : cnt_q - 1'b1;
      end
    end
  end

  // Cast is applied before the word enters the FIFO
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= z_word;
    end
  end

endmodule

// ==== src/streamer_params.svh ====
`ifndef STREAMER_PARAMS_SVH
`define STREAMER_PARAMS_SVH

// Memory word and stream payload width in bits
`define STREAMER_DW 32

// Byte address width of the memory port
`define STREAMER_AW 32

// Load response FIFO depth
// Also the limit on reads in flight plus buffered words
`define STREAMER_LD_DEPTH 4

// Store FIFO depth between Z intake and write issue
`define STREAMER_ST_DEPTH 2

// Width of the word counters of both channels
`define STREAMER_LEN_W 16

`endif

// ==== src/streamer_pkg.sv ====
`include "streamer_params.svh"

package streamer_pkg;

  // In-place format cast applied by both channels
  typedef enum logic {
    CAST_NONE = 1'b0,
    CAST_FP8  = 1'b1
  } cast_mode_e;

  // Address sequencer state
  typedef enum logic {
    ADDR_IDLE = 1'b0,
    ADDR_RUN  = 1'b1
  } addr_state_e;

  // Channel that owns the memory port in the current cycle
  typedef enum logic {
    OWNER_LOAD  = 1'b0,
    OWNER_STORE = 1'b1
  } grant_owner_e;

  // Load cast, two E5M2 bytes from the low half become two FP16 lanes
  // E5M2 is the upper byte of FP16, so the low byte of each lane is zero
  function automatic logic [`STREAMER_DW-1:0] fp8_to_fp16_pair(logic [`STREAMER_DW-1:0] word);
    return {word[15:8], 8'h00, word[7:0], 8'h00};
  endfunction

  // Store cast, keep the upper byte of each FP16 lane (truncation)
  // Packed result sits in the low half, upper half is zero
  function automatic logic [`STREAMER_DW-1:0] fp16_to_fp8_pair(logic [`STREAMER_DW-1:0] word);
    return {16'h0000, word[31:24], word[15:8]};
  endfunction

endpackage

// ==== src/streamer_top.sv ====
`include "streamer_params.svh"

module streamer_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       clear_i,
  input  logic                       start_i,
  input  streamer_pkg::cast_mode_e   cast_mode_i,
  input  logic                       z_priority_i,
  input  logic [`STREAMER_AW-1:0]    ld_base_i,
  input  logic [`STREAMER_AW-1:0]    ld_stride_i,
  input  logic [`STREAMER_LEN_W-1:0] ld_len_i,
  input  logic [`STREAMER_AW-1:0]    st_base_i,
  input  logic [`STREAMER_AW-1:0]    st_stride_i,
  input  logic [`STREAMER_LEN_W-1:0] st_len_i,
  // X stream towards the engine
  output logic                       x_valid_o,
  output logic [`STREAMER_DW-1:0]    x_data_o,
  input  logic                       x_ready_i,
  // Z stream from the engine
  input  logic                       z_valid_i,
  input  logic [`STREAMER_DW-1:0]    z_data_i,
  output logic                       z_ready_o,
  // Shared memory port
  output logic                       tcdm_req_o,
  input  logic                       tcdm_gnt_i,
  output logic [`STREAMER_AW-1:0]    tcdm_add_o,
  output logic                       tcdm_wen_o,
  output logic [`STREAMER_DW-1:0]    tcdm_data_o,
  output logic [`STREAMER_DW/8-1:0]  tcdm_be_o,
  input  logic                       tcdm_r_valid_i,
  input  logic [`STREAMER_DW-1:0]    tcdm_r_data_i,
  output logic                       ld_done_o,
  output logic                       st_done_o
);

  logic                      ld_req;
  logic                      ld_gnt;
  logic [`STREAMER_AW-1:0]   ld_add;
  logic                      st_req;
  logic                      st_gnt;
  logic [`STREAMER_AW-1:0]   st_add;
  logic [`STREAMER_DW-1:0]   st_data;
  logic [`STREAMER_DW/8-1:0] st_be;

  // Responses are in order and only reads get one, so they go straight to load
  load_channel i_load_channel (
    .clk_i       ( clk_i          ),
    .rst_n_i     ( rst_n_i        ),
    .clear_i     ( clear_i        ),
    .start_i     ( start_i        ),
    .cast_mode_i ( cast_mode_i    ),
    .base_i      ( ld_base_i      ),
    .stride_i    ( ld_stride_i    ),
    .len_i       ( ld_len_i       ),
    .gnt_i       ( ld_gnt         ),
    .r_valid_i   ( tcdm_r_valid_i ),
    .r_data_i    ( tcdm_r_data_i  ),
    .x_ready_i   ( x_ready_i      ),
    .req_o       ( ld_req         ),
    .add_o       ( ld_add         ),
    .x_valid_o   ( x_valid_o      ),
    .x_data_o    ( x_data_o       ),
    .done_o      ( ld_done_o      )
  );

  store_channel i_store_channel (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .clear_i     ( clear_i     ),
    .start_i     ( start_i     ),
    .cast_mode_i ( cast_mode_i ),
    .base_i      ( st_base_i   ),
    .stride_i    ( st_stride_i ),
    .len_i       ( st_len_i    ),
    .z_valid_i   ( z_valid_i   ),
    .z_data_i    ( z_data_i    ),
    .gnt_i       ( st_gnt      ),
    .z_ready_o   ( z_ready_o   ),
    .req_o       ( st_req      ),
    .add_o       ( st_add      ),
    .data_o      ( st_data     ),
    .be_o        ( st_be       ),
    .done_o      ( st_done_o   )
  );

  tcdm_arbiter i_tcdm_arbiter (
    .z_priority_i ( z_priority_i ),
    .ld_req_i     ( ld_req       ),
    .ld_add_i     ( ld_add       ),
    .st_req_i     ( st_req       ),
    .st_add_i     ( st_add       ),
    .st_data_i    ( st_data      ),
    .st_be_i      ( st_be        ),
    .tcdm_gnt_i   ( tcdm_gnt_i   ),
    .ld_gnt_o     ( ld_gnt       ),
    .st_gnt_o     ( st_gnt       ),
    .tcdm_req_o   ( tcdm_req_o   ),
    .tcdm_add_o   ( tcdm_add_o   ),
    .tcdm_wen_o   ( tcdm_wen_o   ),
    .tcdm_data_o  ( tcdm_data_o  ),
    .tcdm_be_o    ( tcdm_be_o    )
  );

endmodule

// ==== src/tcdm_arbiter.sv ====
`include "streamer_params.svh"

module tcdm_arbiter (
  input  logic                      z_priority_i,
  input  logic                      ld_req_i,
  input  logic [`STREAMER_AW-1:0]   ld_add_i,
  input  logic                      st_req_i,
  input  logic [`STREAMER_AW-1:0]   st_add_i,
  input  logic [`STREAMER_DW-1:0]   st_data_i,
  input  logic [`STREAMER_DW/8-1:0] st_be_i,
  input  logic                      tcdm_gnt_i,
  output logic                      ld_gnt_o,
  output logic                      st_gnt_o,
  output logic                      tcdm_req_o,
  output logic [`STREAMER_AW-1:0]   tcdm_add_o,
  output logic                      tcdm_wen_o,
  output logic [`STREAMER_DW-1:0]   tcdm_data_o,
  output logic [`STREAMER_DW/8-1:0] tcdm_be_o
);
  import streamer_pkg::*;

  grant_owner_e owner;

  // Store wins a tie only when Z priority is set
  always_comb begin
    if (st_req_i && (z_priority_i || !ld_req_i)) begin
      owner = OWNER_STORE;
    end else begin
      owner = OWNER_LOAD;
    end
  end

  assign tcdm_req_o  = ld_req_i | st_req_i;
  assign tcdm_add_o  = (owner == OWNER_STORE) ? st_add_i : ld_add_i;
  // Load owner means read, wen high
  assign tcdm_wen_o  = (owner == OWNER_LOAD);
  assign tcdm_data_o = (owner == OWNER_STORE) ? st_data_i : '0;
  // Reads fetch the full word
  assign tcdm_be_o   = (owner == OWNER_STORE) ? st_be_i : '1;

  // Grant goes back to the owner only
  assign ld_gnt_o = tcdm_gnt_i & ld_req_i & (owner == OWNER_LOAD);
  assign st_gnt_o = tcdm_gnt_i & st_req_i & (owner == OWNER_STORE);

endmodule
